//--- rtl/rx_line_filter.sv
// ####################################################################
// Synchronizes the raw serial input and removes short glitches by
// a majority vote over the last few samples
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defs.svh"

module rx_line_filter (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_rx,
    output logic o_rx
);

    localparam int depth = `UART_FILT_DEPTH;

    logic             rx_meta;
    logic             rx_sync;
    logic [depth-2:0] hist_q;
    logic [depth-1:0] window;

    // Second sync flop is the newest sample of the voting window
    assign window = {hist_q, rx_sync};

    always_ff @(posedge i_clk, negedge i_nrst) begin
        if (!i_nrst) begin
            // Idle line is high, so the filter starts at mark level
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            hist_q  <= '1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            hist_q  <= window[depth-2:0];
        end
    end

    // Output follows the level held by most of the window
    always_comb begin : vote_proc
        int unsigned ones;

        ones = 0;
        for (int i = 0; i < depth; i++) begin
            ones = ones + int'(window[i]);
        end
        o_rx = (ones > (depth / 2));
    end : vote_proc

endmodule

`default_nettype wire

//--- rtl/rx_msg_packer.sv
// ####################################################################
// Pairs received bytes into 16-bit messages, decodes them as command
// or sample, holds ready until cleared and counts framing errors
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defs.svh"

module rx_msg_packer (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_byte_vld,
    input  logic [7:0]                  i_byte,
    input  logic                        i_frame_err,
    input  logic                        i_rdy_clr,
    output logic                        o_rdy,
    output rx_msg_pkg::msg_kind_e       o_kind,
    output logic [6:0]                  o_addr,
    output logic [7:0]                  o_wdata,
    output logic [14:0]                 o_value,
    output logic [`UART_ERR_CNT_W-1:0]  o_err_cnt
);

    import rx_msg_pkg::*;

    logic                       phase_q;
    logic [7:0]                 first_q;
    rx_msg_u                    msg_q;
    logic                       rdy_q;
    logic [`UART_ERR_CNT_W-1:0] err_cnt_q;
    logic                       msg_done;

    // Second byte of a pair completes a message
    assign msg_done = i_byte_vld && phase_q;

    always_ff @(posedge i_clk, negedge i_nrst) begin
        if (!i_nrst) begin
            phase_q   <= 1'b0;
            rdy_q     <= 1'b0;
            err_cnt_q <= '0;
        end else begin
            if (i_frame_err) begin
                // A bad frame throws away any half-built pair
                phase_q <= 1'b0;
                if (err_cnt_q != '1) begin
                    err_cnt_q <= err_cnt_q + 1'b1;
                end
            end else if (i_byte_vld) begin
                phase_q <= !phase_q;
            end

            // A new message wins over a clear in the same cycle
            if (msg_done) begin
                rdy_q <= 1'b1;
            end else if (i_rdy_clr) begin
                rdy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_byte_vld && !phase_q) begin
            first_q <= i_byte;
        end
        if (msg_done) begin
            msg_q <= {first_q, i_byte};
        end
    end

    // Same word read through both views; the kind tells the host which applies
    assign o_kind    = msg_q.cmd.kind;
    assign o_addr    = msg_q.cmd.addr;
    assign o_wdata   = msg_q.cmd.data;
    assign o_value   = msg_q.smp.value;
    assign o_rdy     = rdy_q;
    assign o_err_cnt = err_cnt_q;

endmodule

`default_nettype wire

//--- rtl/rx_msg_pkg.sv
// ####################################################################
// Types for received messages: the 16-bit word in its two views
// ####################################################################

`default_nettype none

package rx_msg_pkg;

    // Top bit of every message selects how the rest is read
    typedef enum logic {
        MSG_SAMPLE = 1'b0,
        MSG_CMD    = 1'b1
    } msg_kind_e;

    // Register command: address and write data
    typedef struct packed {
        msg_kind_e  kind;
        logic [6:0] addr;
        logic [7:0] data;
    } rx_cmd_t;

    // Sensor sample: one 15-bit value
    typedef struct packed {
        msg_kind_e   kind;
        logic [14:0] value;
    } rx_sample_t;

    // First received byte lands in the upper half
    typedef union packed {
        rx_cmd_t    cmd;
        rx_sample_t smp;
    } rx_msg_u;

endpackage

`default_nettype wire

//--- rtl/uart_line_pkg.sv
// ####################################################################
// Types for the serial line side: framer states and bit counters
// ####################################################################

`default_nettype none

package uart_line_pkg;

    // Receiver phases within one frame
    typedef enum logic [1:0] {
        RX_START = 2'd0,
        RX_DATA  = 2'd1,
        RX_STOP  = 2'd2,
        RX_GUARD = 2'd3
    } rx_state_e;

    // Counts clocks inside one bit, up to twice the scaler
    typedef logic [4:0] sample_cnt_t;

    // Position of the next data bit, 0 to 8
    typedef logic [3:0] bit_pos_t;

endpackage

`default_nettype wire

//--- rtl/uart_rx_defs.svh
// ####################################################################
// Shared constants for the UART receive path: oversampling scaler,
// line filter depth and error counter width. Include where needed
// ####################################################################

`ifndef UART_RX_DEFS_SVH
`define UART_RX_DEFS_SVH

// Half of one bit period in clocks, so a full bit lasts twice this
`define UART_SCALER 8

// Number of line samples voted on by the glitch filter
`define UART_FILT_DEPTH 3

// Width of the saturating framing error counter
`define UART_ERR_CNT_W 8

`endif

//--- rtl/uart_rx_framer.sv
// ####################################################################
// Oversampling UART receiver: frames the filtered line into bytes,
// one strobe per good frame or one error pulse per bad stop bit
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defs.svh"

module uart_rx_framer (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_rx,
    output logic       o_byte_vld,
    output logic [7:0] o_byte,
    output logic       o_frame_err
);

    import uart_line_pkg::*;

    localparam sample_cnt_t sample_max = sample_cnt_t'(2 * `UART_SCALER - 1);
    localparam sample_cnt_t sample_mid = sample_cnt_t'(`UART_SCALER);
    localparam bit_pos_t    last_bit   = bit_pos_t'(8);

    rx_state_e   state_q;
    rx_state_e   state_d;
    sample_cnt_t sample_q;
    sample_cnt_t sample_d;
    bit_pos_t    bitpos_q;
    bit_pos_t    bitpos_d;
    logic [7:0]  shift_q;
    logic [7:0]  shift_d;
    logic        rx_q;
    logic        rx_rise;
    logic        rx_fall;
    logic        vld_q;
    logic        vld_d;
    logic        err_q;
    logic        err_d;

    assign rx_rise = !rx_q && i_rx;
    assign rx_fall = rx_q && !i_rx;

    always_comb begin
        state_d  = state_q;
        sample_d = sample_q;
        bitpos_d = bitpos_q;
        shift_d  = shift_q;
        vld_d    = 1'b0;
        err_d    = 1'b0;

        case (state_q)
            RX_START: begin
                // Count from the first low sample; a full bit or an early
                // rising edge ends the start bit
                if (!i_rx || (sample_q != '0)) begin
                    sample_d = sample_q + 1'b1;
                end
                if ((sample_q == sample_max) || rx_rise) begin
                    state_d  = RX_DATA;
                    sample_d = '0;
                    bitpos_d = '0;
                end
            end
            RX_DATA: begin
                // LSB arrives first, so shift in from the top
                if (sample_q == sample_mid) begin
                    shift_d  = {i_rx, shift_q[7:1]};
                    bitpos_d = bitpos_q + 1'b1;
                end
                // Past the middle, any line edge marks the next bit boundary
                if ((sample_q == sample_max)
                        || ((sample_q > sample_mid) && (rx_rise || rx_fall))) begin
                    sample_d = '0;
                    if (bitpos_q == last_bit) begin
                        state_d = RX_STOP;
                    end
                end else begin
                    sample_d = sample_q + 1'b1;
                end
            end
            RX_STOP: begin
                if (sample_q == sample_mid) begin
                    vld_d = i_rx;
                    err_d = !i_rx;
                end
                if (sample_q == sample_max) begin
                    state_d  = RX_GUARD;
                    sample_d = '0;
                end else begin
                    sample_d = sample_q + 1'b1;
                end
            end
            RX_GUARD: begin
                // Half a bit of quiet before looking for the next start bit
                if (sample_q >= sample_mid) begin
                    state_d  = RX_START;
                    sample_d = '0;
                end else begin
                    sample_d = sample_q + 1'b1;
                end
            end
            default: begin
                state_d = RX_START;
            end
        endcase
    end

    always_ff @(posedge i_clk, negedge i_nrst) begin
        if (!i_nrst) begin
            state_q  <= RX_START;
            sample_q <= '0;
            bitpos_q <= '0;
            rx_q     <= 1'b1;
            vld_q    <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            state_q  <= state_d;
            sample_q <= sample_d;
            bitpos_q <= bitpos_d;
            rx_q     <= i_rx;
            vld_q    <= vld_d;
            err_q    <= err_d;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_q <= shift_d;
    end

    // Shift register holds still from the last data bit to the next frame
    assign o_byte      = shift_q;
    assign o_byte_vld  = vld_q;
    assign o_frame_err = err_q;

endmodule

`default_nettype wire

//--- rtl/uart_rx_top.sv
// ####################################################################
// UART receive subsystem: line filter, byte framer and message
// packer in a chain from the serial pin to decoded fields
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defs.svh"

module uart_rx_top (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_rx,
    input  logic                        i_rdy_clr,
    output logic                        o_rdy,
    output rx_msg_pkg::msg_kind_e       o_kind,
    output logic [6:0]                  o_addr,
    output logic [7:0]                  o_wdata,
    output logic [14:0]                 o_value,
    output logic [`UART_ERR_CNT_W-1:0]  o_err_cnt
);

    logic       rx_filt;
    logic       byte_vld;
    logic [7:0] byte_data;
    logic       frame_err;

    rx_line_filter u_filter (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_rx   (i_rx),
        .o_rx   (rx_filt)
    );

    uart_rx_framer u_framer (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_rx        (rx_filt),
        .o_byte_vld  (byte_vld),
        .o_byte      (byte_data),
        .o_frame_err (frame_err)
    );

    rx_msg_packer u_packer (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_byte_vld  (byte_vld),
        .i_byte      (byte_data),
        .i_frame_err (frame_err),
        .i_rdy_clr   (i_rdy_clr),
        .o_rdy       (o_rdy),
        .o_kind      (o_kind),
        .o_addr      (o_addr),
        .o_wdata     (o_wdata),
        .o_value     (o_value),
        .o_err_cnt   (o_err_cnt)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the UART receive testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_uart_rx -f vlog.f -o tb_uart_rx
sim_out=$(./obj_dir/tb_uart_rx 2>&1) || true
echo "$sim_out"
if grep -qx "sim passed" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

//--- tb/tb_uart_rx.sv
// ####################################################################
// Testbench for the UART receive subsystem that serializes byte pairs
// from the vector file onto the line and checks the decoded fields
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defs.svh"

module tb_uart_rx;

    import rx_msg_pkg::*;

    localparam int bit_clks = 2 * `UART_SCALER;

    typedef struct packed {
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic        ok0;
        logic        ok1;
        logic        glitch;
        logic        clr;
        msg_kind_e   kind;
        logic [6:0]  addr;
        logic [7:0]  wdata;
        logic [14:0] value;
        logic [7:0]  err_cnt;
    } vec_t;

    logic                       i_clk;
    logic                       i_nrst;
    logic                       i_rx;
    logic                       i_rdy_clr;
    logic                       o_rdy;
    msg_kind_e                  o_kind;
    logic [6:0]                 o_addr;
    logic [7:0]                 o_wdata;
    logic [14:0]                o_value;
    logic [`UART_ERR_CNT_W-1:0] o_err_cnt;

    vec_t        vecs[$];
    logic [31:0] lcg_state;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 2000;

    always #4 i_clk = ~i_clk;

    uart_rx_top DUT (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_rx      (i_rx),
        .i_rdy_clr (i_rdy_clr),
        .o_rdy     (o_rdy),
        .o_kind    (o_kind),
        .o_addr    (o_addr),
        .o_wdata   (o_wdata),
        .o_value   (o_value),
        .o_err_cnt (o_err_cnt)
    );

    // Watchdog on the total run length
    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("sim failed");
            $fatal(1);
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic drive_bit(input logic level);
        i_rx = level;
        repeat (bit_clks) @(negedge i_clk);
    endtask

    // Start bit, eight data bits LSB first, then the stop bit
    task automatic send_frame(input logic [7:0] data, input logic stop_ok);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_ok);
    endtask

    // Idle line of 1 to 4 bit times with an optional one-cycle low glitch
    task automatic idle_gap(input logic glitch);
        int unsigned bits;

        lcg_state = lcg_next(lcg_state);
        bits = 1 + (lcg_state[23:16] % 4);
        i_rx = 1'b1;
        if (glitch) begin
            // Glitch lands after the framer has left its guard phase
            if (bits < 2) begin
                bits = 2;
            end
            repeat (bits * bit_clks - 6) @(negedge i_clk);
            i_rx = 1'b0;
            @(negedge i_clk);
            i_rx = 1'b1;
            repeat (5) @(negedge i_clk);
        end else begin
            repeat (bits * bit_clks) @(negedge i_clk);
        end
    endtask

    task automatic wait_rdy();
        while (o_rdy !== 1'b1) begin
            @(negedge i_clk);
        end
    endtask

    task automatic pulse_clear();
        i_rdy_clr = 1'b1;
        @(negedge i_clk);
        i_rdy_clr = 1'b0;
        check_val("o_rdy", 32'(o_rdy), 32'd0);
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        int    b0, b1, ok0, ok1, gl, clr, kind, addr, wdata, value, errc;
        vec_t  v;

        fd = $fopen("tb/uart_rx_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tb/uart_rx_vectors.txt");
            $display("sim failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n <= 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %d %d %d %d %d %h %h %h %d", b0, b1, ok0, ok1,
                        gl, clr, kind, addr, wdata, value, errc);
            if (n <= 0) begin
                continue;
            end
            if (n != 11) begin
                $display("a vector line has %0d fields instead of 11: %s", n, line);
                $display("sim failed");
                $fatal(1);
            end
            v.b0      = b0[7:0];
            v.b1      = b1[7:0];
            v.ok0     = ok0[0];
            v.ok1     = ok1[0];
            v.glitch  = gl[0];
            v.clr     = clr[0];
            v.kind    = msg_kind_e'(kind[0]);
            v.addr    = addr[6:0];
            v.wdata   = wdata[7:0];
            v.value   = value[14:0];
            v.err_cnt = errc[7:0];
            vecs.push_back(v);
        end
        $fclose(fd);
    endtask

    initial begin : main_proc
        vec_t v;
        logic rdy0;

        i_clk     = 1'b0;
        i_nrst    = 1'b0;
        i_rx      = 1'b1;
        i_rdy_clr = 1'b0;
        lcg_state = 32'h49f3;

        load_vectors();
        if (vecs.size() == 0) begin
            $display("the vector file holds no vectors");
            $display("sim failed");
            $fatal(1);
        end
        // Each line sends two frames of at most 10 bits and a 4-bit gap each
        cycle_limit = vecs.size() * 2 * 14 * bit_clks + 2000;

        repeat (5) @(negedge i_clk);
        i_nrst = 1'b1;
        @(negedge i_clk);
        check_val("o_rdy", 32'(o_rdy), 32'd0);
        check_val("o_err_cnt", 32'(o_err_cnt), 32'd0);
        repeat (2 * bit_clks) @(negedge i_clk);

        foreach (vecs[i]) begin
            v = vecs[i];
            rdy0 = o_rdy;
            send_frame(v.b0, v.ok0);
            idle_gap(v.glitch);
            send_frame(v.b1, v.ok1);
            idle_gap(1'b0);
            if (v.ok0 && v.ok1) begin
                wait_rdy();
                check_val("o_kind", 32'(o_kind), 32'(v.kind));
                check_val("o_addr", 32'(o_addr), 32'(v.addr));
                check_val("o_wdata", 32'(o_wdata), 32'(v.wdata));
                check_val("o_value", 32'(o_value), 32'(v.value));
                if (v.clr) begin
                    pulse_clear();
                end
            end else begin
                // A dropped pair leaves the ready level alone
                check_val("o_rdy", 32'(o_rdy), 32'(rdy0));
            end
            check_val("o_err_cnt", 32'(o_err_cnt), 32'(v.err_cnt));
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/uart_rx_vectors.txt
# b0 b1 stop_ok0 stop_ok1 glitch clear kind addr wdata value err_cnt
# bytes and fields in hex, flags and count in decimal, kind 1 is command
85 3C 1 1 0 1 1 05 3C 053C 0
12 34 1 1 0 1 0 12 34 1234 0
FF 00 1 1 0 1 1 7F 00 7F00 0
7A C5 1 1 0 1 0 7A C5 7AC5 0
5A A5 1 0 0 1 0 00 00 0000 1
C3 9E 1 1 0 1 1 43 9E 439E 1
01 80 1 1 1 1 0 01 80 0180 1
66 99 0 0 0 1 0 00 00 0000 3
A0 0F 1 1 0 1 1 20 0F 200F 3
2B 7D 1 1 0 0 0 2B 7D 2B7D 3
E1 5F 1 1 0 1 1 61 5F 615F 3
00 00 1 1 1 1 0 00 00 0000 3
11 22 1 0 0 1 0 00 00 0000 4
80 01 1 1 1 1 1 00 01 0001 4
7F FF 1 1 0 0 0 7F FF 7FFF 4
9C 42 1 1 0 0 1 1C 42 1C42 4
3D 6E 1 1 0 1 0 3D 6E 3D6E 4
F0 0F 0 0 0 1 0 00 00 0000 6
55 AA 1 1 0 1 0 55 AA 55AA 6
D4 C8 1 1 1 1 1 54 C8 54C8 6

//--- vlog.f
+incdir+rtl
rtl/uart_line_pkg.sv
rtl/rx_msg_pkg.sv
rtl/rx_line_filter.sv
rtl/uart_rx_framer.sv
rtl/rx_msg_packer.sv
rtl/uart_rx_top.sv
tb/tb_uart_rx.sv
